//--- include/pinmux_defines.svh
// Pin multiplexer sizing and reset constants
// Pad numbers below are fixed by the pad mux routing
// Register bus is 8-bit byte address, 32-bit data, 4 byte enables
// PWM counts are in microsecond ticks, not milliseconds

`ifndef PINMUX_DEFINES_SVH
`define PINMUX_DEFINES_SVH

// ------------------------------------------------------------
// Widths and counts
// ------------------------------------------------------------

// Pads, one GPIO bit per pad
`define PINMUX_GPIO_W 8

// PWM channels
`define PINMUX_PWM_N 2

// High and low tick counts per PWM channel
`define PINMUX_PWM_W 16

// Tick divider width
`define PINMUX_TICK_W 10

// Register bus
`define PINMUX_REG_AW 8
`define PINMUX_REG_DW 32

// ------------------------------------------------------------
// Reset values
// ------------------------------------------------------------

// 50 cycles per tick, 1us at 50 MHz
`define PINMUX_TICK_RST 49

// ------------------------------------------------------------
// Pad assignment
// ------------------------------------------------------------
`define PINMUX_PAD_UART_RX 0
`define PINMUX_PAD_UART_TX 1
`define PINMUX_PAD_PWM0 2
`define PINMUX_PAD_PWM1 3

`endif

//--- hdl/pinmux_pkg.sv
// Shared types for the pin multiplexer
// Register map offsets are byte addresses, word aligned
// Unlisted addresses read as zero and ignore writes

`default_nettype none

`include "pinmux_defines.svh"

package pinmux_pkg;

  // Plain vector types, usable where the macros are not included
  typedef logic [`PINMUX_GPIO_W-1:0] gpio_vec_t;
  typedef logic [`PINMUX_PWM_N-1:0] pwm_vec_t;
  typedef logic [`PINMUX_TICK_W-1:0] tick_cfg_t;

  // ------------------------------------------------------------
  // Register bus, single-cycle strobe, ack one cycle later
  // ------------------------------------------------------------
  typedef struct packed {
    logic cs;
    logic wr;
    logic [`PINMUX_REG_AW-1:0] addr;
    logic [`PINMUX_REG_DW-1:0] wdata;
    logic [`PINMUX_REG_DW/8-1:0] be;
  } reg_req_t;

  typedef struct packed {
    logic [`PINMUX_REG_DW-1:0] rdata;
    logic ack;
  } reg_rsp_t;

  // GPIO setup, dir 1 means output
  typedef struct packed {
    gpio_vec_t dir;
    gpio_vec_t out;
    gpio_vec_t pos_sel;
    gpio_vec_t neg_sel;
  } gpio_cfg_t;

  // Packed so that uart_en lands on bit 2 of the register
  typedef struct packed {
    logic uart_en;
    pwm_vec_t pwm_en;
  } mfunc_t;

  // High count in bits 15:0, low count in bits 31:16
  typedef struct packed {
    logic [`PINMUX_PWM_W-1:0] low;
    logic [`PINMUX_PWM_W-1:0] high;
  } pwm_cfg_t;

  typedef enum logic [`PINMUX_REG_AW-1:0] {
    REG_GPIO_DIR = 8'h00,
    REG_GPIO_OUT = 8'h04,
    REG_GPIO_IN  = 8'h08,
    REG_EDGE_SEL = 8'h0C,
    REG_INT_STAT = 8'h10,
    REG_INT_MASK = 8'h14,
    REG_MFUNC    = 8'h18,
    REG_TICK_CFG = 8'h1C,
    REG_PWM0     = 8'h20,
    REG_PWM1     = 8'h24
  } reg_addr_e;

endpackage

`default_nettype wire

//--- hdl/pinmux_regs.sv
// Register bank for the pin multiplexer
// One request per strobe; ack and read data follow one cycle later
// Master must not raise cs in the ack cycle
// Interrupt status is sticky, write 1 to clear, new events win
// PWM registers are decoded for exactly two channels

`default_nettype none
`timescale 1ns/100ps

`include "pinmux_defines.svh"

module pinmux_regs (
  input  logic                                     mclk,
  input  logic                                     rst_i,
  input  pinmux_pkg::reg_req_t                     reg_req_i,
  output pinmux_pkg::reg_rsp_t                     reg_rsp_o,
  input  logic [`PINMUX_GPIO_W-1:0]                gpio_in_i,
  input  logic [`PINMUX_GPIO_W-1:0]                gpio_event_i,
  output pinmux_pkg::gpio_cfg_t                    gpio_cfg_o,
  output pinmux_pkg::mfunc_t                       mfunc_o,
  output logic [`PINMUX_TICK_W-1:0]                tick_cfg_o,
  output pinmux_pkg::pwm_cfg_t [`PINMUX_PWM_N-1:0] pwm_cfg_o,
  output logic                                     irq_o
);

  localparam int gpio_w = `PINMUX_GPIO_W;
  localparam int dw = `PINMUX_REG_DW;

  pinmux_pkg::gpio_cfg_t gpio_cfg_q;
  pinmux_pkg::mfunc_t mfunc_q;
  logic [`PINMUX_TICK_W-1:0] tick_q;
  pinmux_pkg::pwm_cfg_t [`PINMUX_PWM_N-1:0] pwm_q;
  logic [gpio_w-1:0] stat_q;
  logic [gpio_w-1:0] mask_q;
  logic [gpio_w-1:0] stat_clr;

  pinmux_pkg::reg_addr_e addr;
  logic wr_en;
  logic rd_en;
  logic [dw-1:0] be_mask;
  logic [dw-1:0] rd_word;
  logic [dw-1:0] wr_val;
  logic [dw-1:0] rdata_q;
  logic ack_q;

  assign addr = pinmux_pkg::reg_addr_e'(reg_req_i.addr);
  assign wr_en = reg_req_i.cs & reg_req_i.wr;
  assign rd_en = reg_req_i.cs & ~reg_req_i.wr;

  // Byte enables widened to a bit mask
  always_comb begin
    for (int b = 0; b < dw / 8; b++) begin
      be_mask[b*8 +: 8] = {8{reg_req_i.be[b]}};
    end
  end

  // ------------------------------------------------------------
  // Read mux, also the base for partial writes
  // ------------------------------------------------------------
  always_comb begin
    rd_word = '0;
    case (addr)
      pinmux_pkg::REG_GPIO_DIR: rd_word[gpio_w-1:0] = gpio_cfg_q.dir;
      pinmux_pkg::REG_GPIO_OUT: rd_word[gpio_w-1:0] = gpio_cfg_q.out;
      pinmux_pkg::REG_GPIO_IN:  rd_word[gpio_w-1:0] = gpio_in_i;
      pinmux_pkg::REG_EDGE_SEL: begin
        rd_word[gpio_w-1:0] = gpio_cfg_q.pos_sel;
        rd_word[gpio_w +: gpio_w] = gpio_cfg_q.neg_sel;
      end
      pinmux_pkg::REG_INT_STAT: rd_word[gpio_w-1:0] = stat_q;
      pinmux_pkg::REG_INT_MASK: rd_word[gpio_w-1:0] = mask_q;
      pinmux_pkg::REG_MFUNC:    rd_word[$bits(mfunc_q)-1:0] = mfunc_q;
      pinmux_pkg::REG_TICK_CFG: rd_word[`PINMUX_TICK_W-1:0] = tick_q;
      pinmux_pkg::REG_PWM0:     rd_word = pwm_q[0];
      pinmux_pkg::REG_PWM1:     rd_word = pwm_q[1];
      default:                  rd_word = '0;
    endcase
  end

  // Unselected bytes keep the current register value
  assign wr_val = (rd_word & ~be_mask) | (reg_req_i.wdata & be_mask);

  // ------------------------------------------------------------
  // Configuration registers
  // ------------------------------------------------------------
  always_ff @(posedge mclk) begin
    if (rst_i) begin
      gpio_cfg_q <= '0;
      mask_q <= '0;
      mfunc_q <= '0;
      tick_q <= `PINMUX_TICK_W'(`PINMUX_TICK_RST);
      pwm_q <= '0;
    end else if (wr_en) begin
      case (addr)
        pinmux_pkg::REG_GPIO_DIR: gpio_cfg_q.dir <= wr_val[gpio_w-1:0];
        pinmux_pkg::REG_GPIO_OUT: gpio_cfg_q.out <= wr_val[gpio_w-1:0];
        pinmux_pkg::REG_EDGE_SEL: begin
          gpio_cfg_q.pos_sel <= wr_val[gpio_w-1:0];
          gpio_cfg_q.neg_sel <= wr_val[gpio_w +: gpio_w];
        end
        pinmux_pkg::REG_INT_MASK: mask_q <= wr_val[gpio_w-1:0];
        pinmux_pkg::REG_MFUNC:
          mfunc_q <= pinmux_pkg::mfunc_t'(wr_val[$bits(mfunc_q)-1:0]);
        pinmux_pkg::REG_TICK_CFG: tick_q <= wr_val[`PINMUX_TICK_W-1:0];
        pinmux_pkg::REG_PWM0:     pwm_q[0] <= pinmux_pkg::pwm_cfg_t'(wr_val);
        pinmux_pkg::REG_PWM1:     pwm_q[1] <= pinmux_pkg::pwm_cfg_t'(wr_val);
        // GPIO_IN, INT_STAT and holes
        default: ;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Interrupt status
  // ------------------------------------------------------------
  assign stat_clr = (wr_en && addr == pinmux_pkg::REG_INT_STAT) ?
                    (reg_req_i.wdata[gpio_w-1:0] & be_mask[gpio_w-1:0]) : '0;

  always_ff @(posedge mclk) begin
    if (rst_i) begin
      stat_q <= '0;
    end else begin
      // Event set overrides a clear in the same cycle
      stat_q <= (stat_q & ~stat_clr) | gpio_event_i;
    end
  end

  assign irq_o = |(stat_q & mask_q);

  // Bus response
  always_ff @(posedge mclk) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= reg_req_i.cs;
    end
  end

  always_ff @(posedge mclk) begin
    rdata_q <= rd_en ? rd_word : '0;
  end

  assign reg_rsp_o = '{rdata: rdata_q, ack: ack_q};

  assign gpio_cfg_o = gpio_cfg_q;
  assign mfunc_o = mfunc_q;
  assign tick_cfg_o = tick_q;
  assign pwm_cfg_o = pwm_q;

endmodule

`default_nettype wire

//--- hdl/tick_gen.sv
// Microsecond tick from a cycle counter
// Tick period is cfg_max_i + 1 cycles
// A new maximum is only picked up at the wrap

`default_nettype none
`timescale 1ns/100ps

`include "pinmux_defines.svh"

module tick_gen (
  input  logic                      mclk,
  input  logic                      rst_i,
  input  logic [`PINMUX_TICK_W-1:0] cfg_max_i,
  output logic                      tick_o
);

  logic [`PINMUX_TICK_W-1:0] cnt_q;
  logic [`PINMUX_TICK_W-1:0] max_q;
  logic wrap;

  // Counter never passes max_q, so equality is enough
  assign wrap = (cnt_q == max_q);

  always_ff @(posedge mclk) begin
    if (rst_i) begin
      cnt_q <= '0;
      max_q <= `PINMUX_TICK_W'(`PINMUX_TICK_RST);
    end else if (wrap) begin
      cnt_q <= '0;
      // Reload here only
      max_q <= cfg_max_i;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign tick_o = wrap;

endmodule

`default_nettype wire

//--- hdl/pwm_channel.sv
// Free-running PWM channel timed by the tick strobe
// Output high for cfg_i.high ticks, low for cfg_i.low ticks
// Zero counts behave as one tick
// Starts in the high phase after reset

`default_nettype none
`timescale 1ns/100ps

`include "pinmux_defines.svh"

module pwm_channel (
  input  logic                 mclk,
  input  logic                 rst_i,
  input  logic                 tick_i,
  input  pinmux_pkg::pwm_cfg_t cfg_i,
  output logic                 wave_o
);

  logic phase_q;
  logic [`PINMUX_PWM_W-1:0] cnt_q;
  logic [`PINMUX_PWM_W-1:0] lim;
  logic last;

  // Tick count for the phase in progress
  always_comb begin
    lim = phase_q ? cfg_i.high : cfg_i.low;
    if (lim == '0) begin
      lim = `PINMUX_PWM_W'(1);
    end
  end

  // Greater-or-equal covers a count lowered mid-phase
  assign last = (cnt_q >= lim - 1'b1);

  always_ff @(posedge mclk) begin
    if (rst_i) begin
      phase_q <= 1'b1;
      cnt_q <= '0;
    end else if (tick_i) begin
      if (last) begin
        phase_q <= ~phase_q;
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign wave_o = phase_q;

endmodule

`default_nettype wire

//--- hdl/gpio_edge_detect.sv
// GPIO input synchroniser and edge event generation
// Two flops per pad, then a third for the previous sample
// Events are one-cycle strobes, three cycles after the pad edge

`default_nettype none
`timescale 1ns/100ps

`include "pinmux_defines.svh"

module gpio_edge_detect (
  input  logic                      mclk,
  input  logic                      rst_i,
  input  logic [`PINMUX_GPIO_W-1:0] pad_in_i,
  input  pinmux_pkg::gpio_cfg_t     cfg_i,
  output logic [`PINMUX_GPIO_W-1:0] gpio_in_o,
  output logic [`PINMUX_GPIO_W-1:0] gpio_event_o
);

  logic [`PINMUX_GPIO_W-1:0] sync1_q;
  logic [`PINMUX_GPIO_W-1:0] sync2_q;
  logic [`PINMUX_GPIO_W-1:0] prev_q;
  logic [`PINMUX_GPIO_W-1:0] rise;
  logic [`PINMUX_GPIO_W-1:0] fall;
  logic [`PINMUX_GPIO_W-1:0] event_q;

  assign rise = sync2_q & ~prev_q;
  assign fall = ~sync2_q & prev_q;

  always_ff @(posedge mclk) begin
    if (rst_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q <= '0;
      event_q <= '0;
    end else begin
      sync1_q <= pad_in_i;
      sync2_q <= sync1_q;
      prev_q <= sync2_q;
      // Only selected edges raise an event
      event_q <= (rise & cfg_i.pos_sel) | (fall & cfg_i.neg_sel);
    end
  end

  assign gpio_in_o = sync2_q;
  assign gpio_event_o = event_q;

endmodule

`default_nettype wire

//--- hdl/pad_mux.sv
// Per-pad output, output enable and input routing
// Purely combinational, oen is active low
// PWM owns pads 2 and 3, UART owns pads 0 and 1 when enabled
// All other cases fall back to plain GPIO

`default_nettype none
`timescale 1ns/100ps

`include "pinmux_defines.svh"

module pad_mux (
  input  pinmux_pkg::gpio_cfg_t     cfg_i,
  input  pinmux_pkg::mfunc_t        mfunc_i,
  input  logic [`PINMUX_PWM_N-1:0]  pwm_wave_i,
  input  logic                      uart_txd_i,
  input  logic [`PINMUX_GPIO_W-1:0] pad_in_i,
  output logic [`PINMUX_GPIO_W-1:0] pad_out_o,
  output logic [`PINMUX_GPIO_W-1:0] pad_oen_o,
  output logic                      uart_rxd_o
);

  // ------------------------------------------------------------
  // Output and output enable
  // ------------------------------------------------------------
  always_comb begin
    // GPIO default, input pads drive 0 and float
    for (int p = 0; p < `PINMUX_GPIO_W; p++) begin
      pad_out_o[p] = cfg_i.dir[p] ? cfg_i.out[p] : 1'b0;
      pad_oen_o[p] = ~cfg_i.dir[p];
    end

    // PWM channel 0
    if (mfunc_i.pwm_en[0]) begin
      pad_out_o[`PINMUX_PAD_PWM0] = pwm_wave_i[0];
      pad_oen_o[`PINMUX_PAD_PWM0] = 1'b0;
    end

    // PWM channel 1
    if (mfunc_i.pwm_en[1]) begin
      pad_out_o[`PINMUX_PAD_PWM1] = pwm_wave_i[1];
      pad_oen_o[`PINMUX_PAD_PWM1] = 1'b0;
    end

    // UART takes both pads, rx side forced to input
    if (mfunc_i.uart_en) begin
      pad_out_o[`PINMUX_PAD_UART_TX] = uart_txd_i;
      pad_oen_o[`PINMUX_PAD_UART_TX] = 1'b0;
      pad_out_o[`PINMUX_PAD_UART_RX] = 1'b0;
      pad_oen_o[`PINMUX_PAD_UART_RX] = 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Input routing
  // ------------------------------------------------------------

  // Held low while UART is off
  assign uart_rxd_o = mfunc_i.uart_en & pad_in_i[`PINMUX_PAD_UART_RX];

endmodule

`default_nettype wire

//--- hdl/pinmux_top.sv
// Pin multiplexer top level, eight pads
// Single clock mclk, synchronous active-high reset
// Register bus has no back-pressure, ack one cycle after cs
// Pad inputs are asynchronous and synchronised inside
// oen is active low on every pad

`default_nettype none
`timescale 1ns/100ps

module pinmux_top (
  input  logic                 mclk,
  input  logic                 rst_i,
  input  pinmux_pkg::reg_req_t reg_req_i,
  output pinmux_pkg::reg_rsp_t reg_rsp_o,
  input  pinmux_pkg::gpio_vec_t pad_in_i,
  output pinmux_pkg::gpio_vec_t pad_out_o,
  output pinmux_pkg::gpio_vec_t pad_oen_o,
  input  logic                 uart_txd_i,
  output logic                 uart_rxd_o,
  output logic                 irq_o
);

  localparam int pwm_n = $bits(pinmux_pkg::pwm_vec_t);

  pinmux_pkg::gpio_cfg_t gpio_cfg;
  pinmux_pkg::mfunc_t mfunc;
  pinmux_pkg::tick_cfg_t tick_cfg;
  pinmux_pkg::pwm_cfg_t [pwm_n-1:0] pwm_cfg;
  pinmux_pkg::gpio_vec_t gpio_in;
  pinmux_pkg::gpio_vec_t gpio_event;
  pinmux_pkg::pwm_vec_t pwm_wave;
  logic tick;

  // ------------------------------------------------------------
  // Register bank
  // ------------------------------------------------------------
  pinmux_regs u_pinmux_regs (
    .mclk         (mclk),
    .rst_i        (rst_i),
    .reg_req_i    (reg_req_i),
    .reg_rsp_o    (reg_rsp_o),
    .gpio_in_i    (gpio_in),
    .gpio_event_i (gpio_event),
    .gpio_cfg_o   (gpio_cfg),
    .mfunc_o      (mfunc),
    .tick_cfg_o   (tick_cfg),
    .pwm_cfg_o    (pwm_cfg),
    .irq_o        (irq_o)
  );

  // GPIO input path
  gpio_edge_detect u_gpio_edge_detect (
    .mclk         (mclk),
    .rst_i        (rst_i),
    .pad_in_i     (pad_in_i),
    .cfg_i        (gpio_cfg),
    .gpio_in_o    (gpio_in),
    .gpio_event_o (gpio_event)
  );

  // ------------------------------------------------------------
  // Tick and PWM
  // ------------------------------------------------------------
  tick_gen u_tick_gen (
    .mclk      (mclk),
    .rst_i     (rst_i),
    .cfg_max_i (tick_cfg),
    .tick_o    (tick)
  );

  // Channels run regardless of pwm_en
  for (genvar i = 0; i < pwm_n; i++) begin : g_pwm
    pwm_channel u_pwm_channel (
      .mclk   (mclk),
      .rst_i  (rst_i),
      .tick_i (tick),
      .cfg_i  (pwm_cfg[i]),
      .wave_o (pwm_wave[i])
    );
  end

  // Pad routing
  pad_mux u_pad_mux (
    .cfg_i      (gpio_cfg),
    .mfunc_i    (mfunc),
    .pwm_wave_i (pwm_wave),
    .uart_txd_i (uart_txd_i),
    .pad_in_i   (pad_in_i),
    .pad_out_o  (pad_out_o),
    .pad_oen_o  (pad_oen_o),
    .uart_rxd_o (uart_rxd_o)
  );

endmodule

`default_nettype wire

//--- testbench/tb_pinmux_top.sv
// Testbench for the eight-pad pin multiplexer
// Bus accesses are single-cycle strobes; ack is expected exactly one cycle later
// Pad routing is checked on every rising edge against a register model
// PWM pad output is not predicted cycle by cycle; phase lengths are measured instead
// Stops at the first mismatch; a cycle counter bounds the run

`default_nettype none
`timescale 1ns/100ps

`include "pinmux_defines.svh"

module tb_pinmux_top;

  localparam int gpio_w = `PINMUX_GPIO_W;
  localparam int cycle_limit = 4000;
  localparam logic [31:0] lfsr_seed = 32'd84193;

  // Expected pad state, care clears out bits owned by a running PWM
  typedef struct packed {
    pinmux_pkg::gpio_vec_t out;
    pinmux_pkg::gpio_vec_t oen;
    pinmux_pkg::gpio_vec_t care;
    logic rxd;
  } pad_exp_t;

  logic mclk;
  logic rst_i;
  pinmux_pkg::reg_req_t reg_req;
  pinmux_pkg::reg_rsp_t reg_rsp;
  pinmux_pkg::gpio_vec_t pad_in;
  pinmux_pkg::gpio_vec_t pad_out;
  pinmux_pkg::gpio_vec_t pad_oen;
  logic uart_txd;
  logic uart_rxd;
  logic irq;

  // Register model, one word per 4-byte slot
  logic [31:0] model_q [0:15];
  pinmux_pkg::gpio_vec_t stat_model;
  logic [31:0] lfsr_q;
  logic pads_on;
  int cycle_cnt;

  pinmux_top u_pinmux_top (
    .mclk       (mclk),
    .rst_i      (rst_i),
    .reg_req_i  (reg_req),
    .reg_rsp_o  (reg_rsp),
    .pad_in_i   (pad_in),
    .pad_out_o  (pad_out),
    .pad_oen_o  (pad_oen),
    .uart_txd_i (uart_txd),
    .uart_rxd_o (uart_rxd),
    .irq_o      (irq)
  );

  always #10 mclk = ~mclk;

  // ------------------------------------------------------------
  // Reporting and compare tasks
  // ------------------------------------------------------------
  task automatic report_fail(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_vec(input string name, input pinmux_pkg::gpio_vec_t exp,
                           input pinmux_pkg::gpio_vec_t act);
    if (act !== exp) begin
      report_fail($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_word(input string name, input logic [`PINMUX_REG_DW-1:0] exp,
                            input logic [`PINMUX_REG_DW-1:0] act);
    if (act !== exp) begin
      report_fail($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_fail($sformatf("FAIL %s expected %b actual %b", name, exp, act));
    end
  endtask

  // ------------------------------------------------------------
  // Random numbers and model helpers
  // ------------------------------------------------------------

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic get_rand(input int n, output logic [31:0] val);
    val = '0;
    repeat (n) begin
      lfsr_q = lfsr_next(lfsr_q);
      val = {val[30:0], lfsr_q[0]};
    end
  endtask

  // Implemented bits of each register
  function automatic logic [31:0] field_mask(input logic [7:0] addr);
    case (addr)
      pinmux_pkg::REG_GPIO_DIR, pinmux_pkg::REG_GPIO_OUT,
      pinmux_pkg::REG_INT_MASK: return 32'h0000_00FF;
      pinmux_pkg::REG_EDGE_SEL: return 32'h0000_FFFF;
      pinmux_pkg::REG_MFUNC:    return 32'h0000_0007;
      pinmux_pkg::REG_TICK_CFG: return 32'h0000_03FF;
      pinmux_pkg::REG_PWM0, pinmux_pkg::REG_PWM1: return 32'hFFFF_FFFF;
      default: return 32'h0;
    endcase
  endfunction

  function automatic logic [7:0] writable_addr(input int k);
    case (k)
      0: return pinmux_pkg::REG_GPIO_DIR;
      1: return pinmux_pkg::REG_GPIO_OUT;
      2: return pinmux_pkg::REG_EDGE_SEL;
      3: return pinmux_pkg::REG_INT_MASK;
      4: return pinmux_pkg::REG_MFUNC;
      5: return pinmux_pkg::REG_TICK_CFG;
      6: return pinmux_pkg::REG_PWM0;
      default: return pinmux_pkg::REG_PWM1;
    endcase
  endfunction

  function automatic logic [31:0] expected_read(input logic [7:0] addr);
    case (addr)
      pinmux_pkg::REG_GPIO_IN:  return {24'h0, pad_in};
      pinmux_pkg::REG_INT_STAT: return {24'h0, stat_model};
      default: return model_q[addr[5:2]] & field_mask(addr);
    endcase
  endfunction

  task automatic model_write(input logic [7:0] addr, input logic [31:0] wdata,
                             input logic [3:0] be);
    logic [31:0] bm;
    bm = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    if (addr == pinmux_pkg::REG_INT_STAT) begin
      stat_model = stat_model & ~(wdata[7:0] & bm[7:0]);
    end else begin
      model_q[addr[5:2]] = ((model_q[addr[5:2]] & ~bm) | (wdata & bm)) & field_mask(addr);
    end
  endtask

  // Pad routing rules, function priority over GPIO
  function automatic pad_exp_t ref_pads(input pinmux_pkg::gpio_vec_t dir,
                                        input pinmux_pkg::gpio_vec_t gout,
                                        input pinmux_pkg::mfunc_t mf,
                                        input pinmux_pkg::gpio_vec_t pin, input logic txd);
    pad_exp_t e;
    for (int p = 0; p < gpio_w; p++) begin
      e.out[p] = dir[p] & gout[p];
      e.oen[p] = ~dir[p];
    end
    e.care = '1;
    e.rxd = 1'b0;
    if (mf.pwm_en[0]) begin
      e.oen[`PINMUX_PAD_PWM0] = 1'b0;
      e.care[`PINMUX_PAD_PWM0] = 1'b0;
    end
    if (mf.pwm_en[1]) begin
      e.oen[`PINMUX_PAD_PWM1] = 1'b0;
      e.care[`PINMUX_PAD_PWM1] = 1'b0;
    end
    if (mf.uart_en) begin
      e.out[`PINMUX_PAD_UART_TX] = txd;
      e.oen[`PINMUX_PAD_UART_TX] = 1'b0;
      e.out[`PINMUX_PAD_UART_RX] = 1'b0;
      e.oen[`PINMUX_PAD_UART_RX] = 1'b1;
      e.rxd = pin[`PINMUX_PAD_UART_RX];
    end
    return e;
  endfunction

  // ------------------------------------------------------------
  // Bus and pad drivers, all on the falling edge
  // ------------------------------------------------------------
  task automatic bus_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            input logic [3:0] be, output logic [31:0] rdata);
    @(negedge mclk);
    check_bit("ack low before cs", 1'b0, reg_rsp.ack);
    reg_req.cs = 1'b1;
    reg_req.wr = wr;
    reg_req.addr = addr;
    reg_req.wdata = wdata;
    reg_req.be = be;
    @(negedge mclk);
    reg_req.cs = 1'b0;
    reg_req.wr = 1'b0;
    check_bit("ack one cycle after cs", 1'b1, reg_rsp.ack);
    rdata = reg_rsp.rdata;
    // Register has taken the write at the last rising edge
    if (wr) begin
      model_write(addr, wdata, be);
    end
    @(negedge mclk);
    check_bit("ack single cycle", 1'b0, reg_rsp.ack);
  endtask

  task automatic bus_write(input logic [7:0] addr, input logic [31:0] wdata,
                           input logic [3:0] be);
    logic [31:0] unused;
    bus_access(1'b1, addr, wdata, be, unused);
  endtask

  task automatic read_check(input string name, input logic [7:0] addr);
    logic [31:0] rdata;
    bus_access(1'b0, addr, 32'h0, 4'h0, rdata);
    check_word(name, expected_read(addr), rdata);
  endtask

  // Selected edges go into the status model at drive time
  task automatic drive_pads(input pinmux_pkg::gpio_vec_t value);
    pinmux_pkg::gpio_vec_t rise;
    pinmux_pkg::gpio_vec_t fall;
    @(negedge mclk);
    rise = value & ~pad_in;
    fall = ~value & pad_in;
    stat_model = stat_model | (rise & model_q[3][7:0]) | (fall & model_q[3][15:8]);
    pad_in = value;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge mclk);
  endtask

  // Pad compare on every rising edge, model and pads both settled
  always @(posedge mclk) begin : pad_compare
    pad_exp_t e;
    if (pads_on) begin
      e = ref_pads(model_q[0][7:0], model_q[1][7:0],
                   pinmux_pkg::mfunc_t'(model_q[6][2:0]), pad_in, uart_txd);
      check_vec("pad_out", e.out & e.care, pad_out & e.care);
      check_vec("pad_oen", e.oen, pad_oen);
      check_bit("uart_rxd", e.rxd, uart_rxd);
    end
  end

  // Run limit
  always @(posedge mclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: tests did not finish within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $fatal(1, "run limit reached");
    end
  end

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------
  task automatic reset_state;
    check_vec("reset pad_oen", '1, pad_oen);
    check_vec("reset pad_out", '0, pad_out);
    check_bit("reset irq", 1'b0, irq);
    check_bit("reset uart_rxd", 1'b0, uart_rxd);
    for (int a = 0; a <= 9; a++) begin
      read_check("reset value", 8'(a * 4));
    end
  endtask

  task automatic register_access;
    logic [31:0] val;
    logic [31:0] bev;
    for (int k = 0; k < 8; k++) begin
      for (int i = 0; i < 4; i++) begin
        get_rand(32, val);
        get_rand(4, bev);
        bus_write(writable_addr(k), val, bev[3:0]);
        read_check("register readback", writable_addr(k));
      end
    end
    // Read-only and unmapped writes are dropped
    bus_write(pinmux_pkg::REG_GPIO_IN, 32'hFFFF_FFFF, 4'hF);
    read_check("gpio_in after write", pinmux_pkg::REG_GPIO_IN);
    bus_write(8'h28, 32'hFFFF_FFFF, 4'hF);
    read_check("unmapped read", 8'h28);
    bus_write(pinmux_pkg::REG_EDGE_SEL, 32'h0, 4'hF);
    bus_write(pinmux_pkg::REG_INT_MASK, 32'h0, 4'hF);
    bus_write(pinmux_pkg::REG_MFUNC, 32'h0, 4'hF);
  endtask

  task automatic gpio_routing;
    logic [31:0] val;
    repeat (16) begin
      get_rand(8, val);
      bus_write(pinmux_pkg::REG_GPIO_DIR, val, 4'h1);
      get_rand(8, val);
      bus_write(pinmux_pkg::REG_GPIO_OUT, val, 4'h1);
      get_rand(8, val);
      drive_pads(val[7:0]);
      wait_cycles(4);
      read_check("gpio_in", pinmux_pkg::REG_GPIO_IN);
    end
  endtask

  task automatic edge_interrupts;
    logic [31:0] val;
    for (int r = 0; r < 4; r++) begin
      get_rand(16, val);
      bus_write(pinmux_pkg::REG_EDGE_SEL, val, 4'h3);
      get_rand(8, val);
      bus_write(pinmux_pkg::REG_INT_MASK, val, 4'h1);
      repeat (4) begin
        get_rand(8, val);
        drive_pads(val[7:0]);
        wait_cycles(4);
      end
      // Let the last events reach the status register
      wait_cycles(6);
      check_bit("irq after edges", |(stat_model & model_q[5][7:0]), irq);
      read_check("int_stat after edges", pinmux_pkg::REG_INT_STAT);
      get_rand(8, val);
      bus_write(pinmux_pkg::REG_INT_STAT, val, 4'h1);
      read_check("int_stat after clear", pinmux_pkg::REG_INT_STAT);
      check_bit("irq after clear", |(stat_model & model_q[5][7:0]), irq);
    end
    bus_write(pinmux_pkg::REG_EDGE_SEL, 32'h0, 4'h3);
  endtask

  task automatic uart_routing;
    logic [31:0] val;
    bus_write(pinmux_pkg::REG_GPIO_DIR, 32'hFF, 4'h1);
    get_rand(8, val);
    bus_write(pinmux_pkg::REG_GPIO_OUT, val, 4'h1);
    bus_write(pinmux_pkg::REG_MFUNC, 32'h4, 4'h1);
    repeat (8) begin
      get_rand(9, val);
      @(negedge mclk);
      uart_txd = val[8];
      drive_pads(val[7:0]);
      wait_cycles(2);
      check_bit("uart tx pad", uart_txd, pad_out[`PINMUX_PAD_UART_TX]);
      check_bit("uart rx pad oen", 1'b1, pad_oen[`PINMUX_PAD_UART_RX]);
      check_bit("uart_rxd follows pad", pad_in[`PINMUX_PAD_UART_RX], uart_rxd);
    end
    bus_write(pinmux_pkg::REG_MFUNC, 32'h0, 4'h1);
  endtask

  // Phase lengths on one PWM pad, in cycles between output changes
  task automatic measure_pwm(input int pad, input string name,
                             input logic [31:0] high_cyc, input logic [31:0] low_cyc);
    logic [31:0] cnt;
    logic last;
    int skip;
    int phases;
    last = pad_out[pad];
    cnt = '0;
    skip = 2;
    phases = 0;
    while (phases < 6) begin
      @(negedge mclk);
      cnt = cnt + 1;
      if (pad_out[pad] !== last) begin
        // First phases may be cut short by the configuration change
        if (skip > 0) begin
          skip = skip - 1;
        end else if (last) begin
          check_word($sformatf("%s high phase cycles", name), high_cyc, cnt);
          phases = phases + 1;
        end else begin
          check_word($sformatf("%s low phase cycles", name), low_cyc, cnt);
          phases = phases + 1;
        end
        check_bit($sformatf("%s pad oen", name), 1'b0, pad_oen[pad]);
        last = pad_out[pad];
        cnt = '0;
      end
    end
  endtask

  task automatic pwm_timing;
    logic [31:0] val;
    bus_write(pinmux_pkg::REG_TICK_CFG, 32'd3, 4'h3);
    // New divider only loads at a wrap of the old one
    wait_cycles(`PINMUX_TICK_RST + 10);
    bus_write(pinmux_pkg::REG_PWM0, {16'd5, 16'd3}, 4'hF);
    bus_write(pinmux_pkg::REG_PWM1, {16'd2, 16'd4}, 4'hF);
    // Four cycles per tick
    bus_write(pinmux_pkg::REG_MFUNC, 32'h1, 4'h1);
    measure_pwm(`PINMUX_PAD_PWM0, "pwm0", 32'd12, 32'd20);
    bus_write(pinmux_pkg::REG_MFUNC, 32'h2, 4'h1);
    measure_pwm(`PINMUX_PAD_PWM1, "pwm1", 32'd16, 32'd8);
    bus_write(pinmux_pkg::REG_MFUNC, 32'h0, 4'h1);
    get_rand(8, val);
    bus_write(pinmux_pkg::REG_GPIO_DIR, val | 32'h4, 4'h1);
    wait_cycles(2);
    check_bit("pad 2 back to gpio", model_q[1][`PINMUX_PAD_PWM0],
              pad_out[`PINMUX_PAD_PWM0]);
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    mclk = 1'b0;
    rst_i = 1'b1;
    reg_req = '0;
    pad_in = '0;
    uart_txd = 1'b0;
    pads_on = 1'b0;
    cycle_cnt = 0;
    lfsr_q = lfsr_seed;
    stat_model = '0;
    for (int i = 0; i < 16; i++) begin
      model_q[i] = '0;
    end
    model_q[7] = `PINMUX_TICK_RST;

    wait_cycles(10);
    rst_i = 1'b0;
    pads_on = 1'b1;
    wait_cycles(2);

    reset_state();
    register_access();
    gpio_routing();
    edge_interrupts();
    uart_routing();
    pwm_timing();

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- pinmux_top.f
+incdir+include
hdl/pinmux_pkg.sv
hdl/pinmux_regs.sv
hdl/tick_gen.sv
hdl/pwm_channel.sv
hdl/gpio_edge_detect.sv
hdl/pad_mux.sv
hdl/pinmux_top.sv
testbench/tb_pinmux_top.sv

//--- Bender.yml
package:
  name: pinmux_top

export_include_dirs:
  - include

sources:
  - hdl/pinmux_pkg.sv
  - hdl/pinmux_regs.sv
  - hdl/tick_gen.sv
  - hdl/pwm_channel.sv
  - hdl/gpio_edge_detect.sv
  - hdl/pad_mux.sv
  - hdl/pinmux_top.sv
  - target: simulation
    files:
      - testbench/tb_pinmux_top.sv
